// ==== common/conv_pkg.sv ====
package conv_pkg;

    // data and kernel sizes
    localparam int WORD_W    = 16;
    localparam int ACC_W     = 2 * WORD_W;
    localparam int KERNEL_W  = 2;
    localparam int KERNEL_H  = 3;
    localparam int KERNEL_N  = KERNEL_W * KERNEL_H;
    localparam int NUM_NODES = 4;

    // wishbone word address map
    localparam int ADR_W = 8;
    localparam logic [ADR_W-1:0] ADDR_CTRL   = 8'h00;
    localparam logic [ADR_W-1:0] ADDR_STATUS = 8'h01;
    localparam logic [ADR_W-1:0] ADDR_BIAS   = 8'h02;
    localparam logic [ADR_W-1:0] ADDR_KERNEL = 8'h08;
    localparam logic [ADR_W-1:0] ADDR_WINDOW = 8'h10;
    localparam logic [ADR_W-1:0] ADDR_RESULT = 8'h40;

    // each node owns 8 window words, only the first KERNEL_N are kept
    localparam int WINDOW_STRIDE = 8;
    localparam int NODE_IDX_W    = $clog2(NUM_NODES);
    localparam int TAP_IDX_W     = $clog2(WINDOW_STRIDE);

    localparam logic [ADR_W-1:0] KERNEL_SPAN = ADR_W'(KERNEL_N);
    localparam logic [ADR_W-1:0] WINDOW_SPAN = ADR_W'(WINDOW_STRIDE * NUM_NODES);
    localparam logic [ADR_W-1:0] RESULT_SPAN = ADR_W'(NUM_NODES);

    typedef logic signed [WORD_W-1:0] word_t;

    // largest positive word, used as the saturation limit
    localparam word_t SAT_MAX = 16'h7FFF;

    // kernel or window taps, row-major
    typedef word_t [KERNEL_N-1:0] tap_array_t;

    typedef enum logic [2:0] {
        REGION_CTRL,
        REGION_STATUS,
        REGION_BIAS,
        REGION_KERNEL,
        REGION_WINDOW,
        REGION_RESULT,
        REGION_NONE
    } addr_region_e;

    typedef enum logic [1:0] {
        NODE_IDLE,
        NODE_MAC,
        NODE_BIAS,
        NODE_OUT
    } node_state_e;

    typedef struct packed {
        logic                  valid;
        addr_region_e          region;
        logic [NODE_IDX_W-1:0] node;
        logic [TAP_IDX_W-1:0]  tap;
        word_t                 data;
    } wr_req_t;

    typedef struct packed {
        logic  valid;
        word_t value;
    } node_result_t;

endpackage

// ==== src/conv_wb_regs.sv ====
`timescale 1ns/1ps

module conv_wb_regs (
    input  logic                                     clk_i,
    input  logic                                     reset_i,
    input  logic                                     wb_cyc_i,
    input  logic                                     wb_stb_i,
    input  logic                                     wb_we_i,
    input  logic [conv_pkg::ADR_W-1:0]               wb_adr_i,
    input  logic [conv_pkg::WORD_W-1:0]              wb_dat_i,
    input  conv_pkg::word_t [conv_pkg::NUM_NODES-1:0] results_i,
    input  logic                                     busy_i,
    input  logic                                     done_i,
    output logic [conv_pkg::WORD_W-1:0]              wb_dat_o,
    output logic                                     wb_ack_o,
    output conv_pkg::wr_req_t                        wr_req_o,
    output logic                                     batch_start_o,
    output conv_pkg::tap_array_t                     kernel_o,
    output conv_pkg::word_t                          bias_o
);
    import conv_pkg::*;

    addr_region_e          region;
    logic [NODE_IDX_W-1:0] node_idx;
    logic [TAP_IDX_W-1:0]  tap_idx;
    logic [ADR_W-1:0]      kernel_off;
    logic [ADR_W-1:0]      window_off;
    logic [ADR_W-1:0]      result_off;
    logic                  acked_q;
    logic                  wr_en;
    logic [WORD_W-1:0]     rd_data;
    tap_array_t            kernel_q;
    word_t                 bias_q;

    assign kernel_off = wb_adr_i - ADDR_KERNEL;
    assign window_off = wb_adr_i - ADDR_WINDOW;
    assign result_off = wb_adr_i - ADDR_RESULT;

    // address decode into region plus node and tap indices
    always_comb begin
        region   = REGION_NONE;
        node_idx = '0;
        tap_idx  = '0;
        if (wb_adr_i == ADDR_CTRL) begin
            region = REGION_CTRL;
        end else if (wb_adr_i == ADDR_STATUS) begin
            region = REGION_STATUS;
        end else if (wb_adr_i == ADDR_BIAS) begin
            region = REGION_BIAS;
        end else if (wb_adr_i >= ADDR_KERNEL && kernel_off < KERNEL_SPAN) begin
            region  = REGION_KERNEL;
            tap_idx = kernel_off[TAP_IDX_W-1:0];
        end else if (wb_adr_i >= ADDR_WINDOW && window_off < WINDOW_SPAN) begin
            region   = REGION_WINDOW;
            node_idx = window_off[TAP_IDX_W +: NODE_IDX_W];
            tap_idx  = window_off[TAP_IDX_W-1:0];
        end else if (wb_adr_i >= ADDR_RESULT && result_off < RESULT_SPAN) begin
            region   = REGION_RESULT;
            node_idx = result_off[NODE_IDX_W-1:0];
        end
    end

    // single-cycle ack, re-armed once stb drops
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            acked_q  <= 1'b0;
        end else begin
            wb_ack_o <= wb_cyc_i && wb_stb_i && !wb_ack_o && !acked_q;
            if (wb_ack_o)
                acked_q <= 1'b1;
            else if (!wb_stb_i)
                acked_q <= 1'b0;
        end
    end

    assign wr_en = wb_ack_o && wb_we_i;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            kernel_q <= '0;
            bias_q   <= '0;
        end else if (wr_en) begin
            if (region == REGION_KERNEL)
                kernel_q[tap_idx] <= wb_dat_i;
            if (region == REGION_BIAS)
                bias_q <= wb_dat_i;
        end
    end

    // start is dropped while a batch is still running
    assign batch_start_o = wr_en && (region == REGION_CTRL) && wb_dat_i[0] && !busy_i;

    assign wr_req_o.valid  = wr_en;
    assign wr_req_o.region = region;
    assign wr_req_o.node   = node_idx;
    assign wr_req_o.tap    = tap_idx;
    assign wr_req_o.data   = wb_dat_i;

    assign kernel_o = kernel_q;
    assign bias_o   = bias_q;

    always_comb begin
        rd_data = '0;
        case (region)
            REGION_STATUS: rd_data = {{(WORD_W-2){1'b0}}, done_i, busy_i};
            REGION_BIAS:   rd_data = bias_q;
            REGION_KERNEL: rd_data = kernel_q[tap_idx];
            REGION_RESULT: rd_data = results_i[node_idx];
            default:       rd_data = '0;
        endcase
    end

    // read data only while a read is being acked
    assign wb_dat_o = (wb_ack_o && !wb_we_i) ? rd_data : '0;

endmodule

// ==== conv_node/conv_node.sv ====
`timescale 1ns/1ps

module conv_node (
    input  logic                 clk_i,
    input  logic                 reset_i,
    input  logic                 start_i,
    input  conv_pkg::tap_array_t window_i,
    input  conv_pkg::tap_array_t kernel_i,
    input  conv_pkg::word_t      bias_i,
    output conv_pkg::node_result_t result_o
);
    import conv_pkg::*;

    node_state_e              state_q;
    node_state_e              state_d;
    logic [TAP_IDX_W-1:0]     tap_q;
    logic                     last_tap;
    word_t                    win_tap;
    word_t                    ker_tap;
    logic signed [ACC_W-1:0]  product;
    logic signed [ACC_W-1:0]  bias_ext;
    logic signed [ACC_W-1:0]  acc_q;
    logic signed [ACC_W-1:0]  sat_max_ext;
    word_t                    out_value;

    assign last_tap = (tap_q == TAP_IDX_W'(KERNEL_N - 1));

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            NODE_IDLE: begin
                if (start_i)
                    state_d = NODE_MAC;
            end
            NODE_MAC: begin
                if (last_tap)
                    state_d = NODE_BIAS;
            end
            NODE_BIAS: state_d = NODE_OUT;
            NODE_OUT:  state_d = NODE_IDLE;
            default:   state_d = NODE_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= NODE_IDLE;
            tap_q   <= '0;
        end else begin
            state_q <= state_d;
            // tap counter only advances through the MAC phase
            if (state_q == NODE_MAC && !last_tap)
                tap_q <= tap_q + 1'b1;
            else
                tap_q <= '0;
        end
    end

    // one signed product per cycle, sign extended to the accumulator
    assign win_tap  = window_i[tap_q];
    assign ker_tap  = kernel_i[tap_q];
    assign product  = ACC_W'(win_tap) * ACC_W'(ker_tap);
    assign bias_ext = ACC_W'(bias_i);

    always_ff @(posedge clk_i) begin
        case (state_q)
            NODE_IDLE: acc_q <= '0;
            NODE_MAC:  acc_q <= acc_q + product;
            // bias acts as a threshold
            NODE_BIAS: acc_q <= acc_q - bias_ext;
            default:   acc_q <= acc_q;
        endcase
    end

    // relu then clamp to the largest positive word
    assign sat_max_ext = ACC_W'(SAT_MAX);

    always_comb begin
        if (acc_q < 0)
            out_value = '0;
        else if (acc_q > sat_max_ext)
            out_value = SAT_MAX;
        else
            out_value = acc_q[WORD_W-1:0];
    end

    assign result_o.valid = (state_q == NODE_OUT);
    assign result_o.value = out_value;

endmodule

// ==== src/conv_window_loader.sv ====
`timescale 1ns/1ps

module conv_window_loader (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  conv_pkg::wr_req_t                             wr_req_i,
    input  logic                                          batch_start_i,
    output conv_pkg::tap_array_t [conv_pkg::NUM_NODES-1:0] windows_o,
    output logic                                          node_start_o
);
    import conv_pkg::*;

    tap_array_t [NUM_NODES-1:0] windows_q;
    logic                       is_window;
    logic                       tap_ok;
    logic                       buf_we;
    logic                       node_start_q;

    // only window writes within the kernel footprint land in a buffer
    assign is_window = (wr_req_i.region == REGION_WINDOW);
    assign tap_ok    = (wr_req_i.tap < TAP_IDX_W'(KERNEL_N));
    assign buf_we    = wr_req_i.valid && is_window && tap_ok;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            windows_q <= '0;
        end else if (buf_we) begin
            windows_q[wr_req_i.node][wr_req_i.tap] <= wr_req_i.data;
        end
    end

    // one cycle of delay so windows are settled when nodes start
    always_ff @(posedge clk_i) begin
        if (reset_i)
            node_start_q <= 1'b0;
        else
            node_start_q <= batch_start_i;
    end

    assign windows_o    = windows_q;
    assign node_start_o = node_start_q;

endmodule

// ==== src/conv_result_collector.sv ====
`timescale 1ns/1ps

module conv_result_collector (
    input  logic                                            clk_i,
    input  logic                                            reset_i,
    input  logic                                            batch_start_i,
    input  conv_pkg::node_result_t [conv_pkg::NUM_NODES-1:0] node_results_i,
    output conv_pkg::word_t [conv_pkg::NUM_NODES-1:0]        results_o,
    output logic                                            busy_o,
    output logic                                            done_o
);
    import conv_pkg::*;

    word_t [NUM_NODES-1:0] results_q;
    logic [NUM_NODES-1:0]  valid_vec;
    logic [NUM_NODES-1:0]  reported_q;
    logic [NUM_NODES-1:0]  reported_d;
    logic                  busy_q;
    logic                  done_q;

    always_comb begin
        for (int n = 0; n < NUM_NODES; n++)
            valid_vec[n] = node_results_i[n].valid;
    end

    assign reported_d = reported_q | valid_vec;

    // capture each node's value as it reports
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            results_q <= '0;
        end else begin
            for (int n = 0; n < NUM_NODES; n++) begin
                if (valid_vec[n])
                    results_q[n] <= node_results_i[n].value;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            reported_q <= '0;
            busy_q     <= 1'b0;
            done_q     <= 1'b0;
        end else if (batch_start_i) begin
            reported_q <= '0;
            busy_q     <= 1'b1;
            done_q     <= 1'b0;
        end else if (busy_q) begin
            reported_q <= reported_d;
            // last node in, batch finished
            if (&reported_d) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    assign results_o = results_q;
    assign busy_o    = busy_q;
    assign done_o    = done_q;

endmodule

// ==== src/conv_layer_top.sv ====
`timescale 1ns/1ps

module conv_layer_top (
    input  logic                        clk_i,
    input  logic                        reset_i,
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [conv_pkg::ADR_W-1:0]  wb_adr_i,
    input  logic [conv_pkg::WORD_W-1:0] wb_dat_i,
    output logic [conv_pkg::WORD_W-1:0] wb_dat_o,
    output logic                        wb_ack_o
);
    import conv_pkg::*;

    wr_req_t                      wr_req;
    logic                         batch_start;
    tap_array_t                   kernel;
    word_t                        bias;
    tap_array_t [NUM_NODES-1:0]   windows;
    logic                         node_start;
    node_result_t [NUM_NODES-1:0] node_results;
    word_t [NUM_NODES-1:0]        results;
    logic                         busy;
    logic                         done;

    conv_wb_regs regs_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .wb_cyc_i      (wb_cyc_i),
        .wb_stb_i      (wb_stb_i),
        .wb_we_i       (wb_we_i),
        .wb_adr_i      (wb_adr_i),
        .wb_dat_i      (wb_dat_i),
        .results_i     (results),
        .busy_i        (busy),
        .done_i        (done),
        .wb_dat_o      (wb_dat_o),
        .wb_ack_o      (wb_ack_o),
        .wr_req_o      (wr_req),
        .batch_start_o (batch_start),
        .kernel_o      (kernel),
        .bias_o        (bias)
    );

    conv_window_loader loader_i (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .wr_req_i      (wr_req),
        .batch_start_i (batch_start),
        .windows_o     (windows),
        .node_start_o  (node_start)
    );

    // kernel and bias are shared, each node sees its own window
    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node
        conv_node node_i (
            .clk_i    (clk_i),
            .reset_i  (reset_i),
            .start_i  (node_start),
            .window_i (windows[n]),
            .kernel_i (kernel),
            .bias_i   (bias),
            .result_o (node_results[n])
        );
    end

    conv_result_collector collector_i (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .batch_start_i  (batch_start),
        .node_results_i (node_results),
        .results_o      (results),
        .busy_o         (busy),
        .done_o         (done)
    );

endmodule

// ==== tb/conv_layer_chk.sv ====
`timescale 1ns/1ps

module conv_layer_chk (
    input logic                                            clk_i,
    input logic                                            reset_i,
    input logic                                            wb_cyc_i,
    input logic                                            wb_stb_i,
    input logic                                            wb_ack_i,
    input logic                                            busy_i,
    input logic                                            done_i,
    input logic                                            node_start_i,
    input conv_pkg::node_result_t [conv_pkg::NUM_NODES-1:0] node_results_i
);
    import conv_pkg::*;

    int error_count = 0;

    // ack only answers a live request
    ack_needs_req: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_ack_i |-> (wb_cyc_i && wb_stb_i))
        else begin
            error_count++;
            $error("ack seen without cyc and stb");
        end

    ack_one_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
        wb_ack_i |=> !wb_ack_i)
        else begin
            error_count++;
            $error("ack held for two cycles");
        end

    ack_low_in_reset: assert property (@(posedge clk_i) reset_i |=> !wb_ack_i)
        else begin
            error_count++;
            $error("ack high during reset");
        end

    done_not_busy: assert property (@(posedge clk_i) disable iff (reset_i)
        !(done_i && busy_i))
        else begin
            error_count++;
            $error("done and busy high together");
        end

    // result valid exactly KERNEL_N + 2 cycles after start, never otherwise
    for (genvar n = 0; n < NUM_NODES; n++) begin : g_node_chk
        node_latency: assert property (@(posedge clk_i) disable iff (reset_i)
            node_start_i |-> ##(KERNEL_N + 2) node_results_i[n].valid)
            else begin
                error_count++;
                $error("node result late or missing");
            end

        node_no_stray: assert property (@(posedge clk_i) disable iff (reset_i)
            node_results_i[n].valid |-> $past(node_start_i, KERNEL_N + 2))
            else begin
                error_count++;
                $error("node result without matching start");
            end
    end

endmodule

bind conv_layer_top conv_layer_chk chk_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wb_cyc_i       (wb_cyc_i),
    .wb_stb_i       (wb_stb_i),
    .wb_ack_i       (wb_ack_o),
    .busy_i         (busy),
    .done_i         (done),
    .node_start_i   (node_start),
    .node_results_i (node_results)
);

// ==== tb/conv_layer_tb.sv ====
`timescale 1ns/1ps

module conv_layer_tb;
    import conv_pkg::*;

    localparam int ACK_TIMEOUT  = 20;
    localparam int DONE_TIMEOUT = 50;

    logic              clk_i;
    logic              reset_i;
    logic              wb_cyc_i;
    logic              wb_stb_i;
    logic              wb_we_i;
    logic [ADR_W-1:0]  wb_adr_i;
    logic [WORD_W-1:0] wb_dat_i;
    logic [WORD_W-1:0] wb_dat_o;
    logic              wb_ack_o;

    // host side copy of what was loaded into the DUT
    tap_array_t kernel_m;
    tap_array_t windows_m [NUM_NODES];
    word_t      bias_m;
    int         cycle_cnt = 0;
    int         ack_cycle = 0;

    conv_layer_top dut_i (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_we_i  (wb_we_i),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_dat_o (wb_dat_o),
        .wb_ack_o (wb_ack_o)
    );

    always #10 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // sum of products, minus bias, relu, clamp to largest positive word
    function automatic word_t model_result(tap_array_t win, tap_array_t ker, word_t b);
        longint sum;
        longint sat;
        sat = (longint'(1) <<< (WORD_W - 1)) - 1;
        sum = 0;
        for (int t = 0; t < KERNEL_N; t++)
            sum += longint'(win[t]) * longint'(ker[t]);
        sum -= longint'(b);
        if (sum < 0)
            return '0;
        if (sum > sat)
            return word_t'(sat);
        return word_t'(sum);
    endfunction

    function automatic word_t rand_word(int lo, int hi);
        return word_t'(lo + int'($urandom_range(hi - lo)));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                              input logic [WORD_W-1:0] got);
        assert (got === exp) else begin
            $display("FAILED %s expected 0x%h got 0x%h", name, exp, got);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic bus_access(input logic we, input logic [ADR_W-1:0] adr,
                              input logic [WORD_W-1:0] wdata, output logic [WORD_W-1:0] rdata);
        int waited;
        waited = 0;
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= we;
        wb_adr_i <= adr;
        wb_dat_i <= wdata;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > ACK_TIMEOUT)
                abort_run("no wishbone ack within the timeout");
        end while (!wb_ack_o);
        rdata     = wb_dat_o;
        ack_cycle = cycle_cnt;
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        // idle cycle so the slave re-arms its ack
        @(posedge clk_i);
    endtask

    task automatic bus_write(input logic [ADR_W-1:0] adr, input logic [WORD_W-1:0] data);
        logic [WORD_W-1:0] unused;
        bus_access(1'b1, adr, data, unused);
    endtask

    task automatic bus_read(input logic [ADR_W-1:0] adr, output logic [WORD_W-1:0] data);
        bus_access(1'b0, adr, '0, data);
    endtask

    task automatic wait_done();
        logic [WORD_W-1:0] status;
        int polls;
        polls  = 0;
        status = '0;
        while (status[1] !== 1'b1) begin
            if (polls == DONE_TIMEOUT)
                abort_run("batch never reported done");
            bus_read(ADDR_STATUS, status);
            polls++;
        end
        check_word("status", 16'h0002, status);
    endtask

    task automatic fill_random(input int lo, input int hi);
        bias_m = rand_word(lo, hi);
        for (int t = 0; t < KERNEL_N; t++)
            kernel_m[t] = rand_word(lo, hi);
        for (int n = 0; n < NUM_NODES; n++)
            for (int t = 0; t < KERNEL_N; t++)
                windows_m[n][t] = rand_word(lo, hi);
    endtask

    task automatic load_operands();
        bus_write(ADDR_BIAS, bias_m);
        for (int t = 0; t < KERNEL_N; t++)
            bus_write(ADDR_KERNEL + ADR_W'(t), kernel_m[t]);
        for (int n = 0; n < NUM_NODES; n++)
            for (int t = 0; t < KERNEL_N; t++)
                bus_write(ADDR_WINDOW + ADR_W'(n * WINDOW_STRIDE + t), windows_m[n][t]);
    endtask

    task automatic check_results();
        logic [WORD_W-1:0] got;
        for (int n = 0; n < NUM_NODES; n++) begin
            bus_read(ADDR_RESULT + ADR_W'(n), got);
            check_word($sformatf("result%0d", n),
                       model_result(windows_m[n], kernel_m, bias_m), got);
        end
    endtask

    task automatic run_batch();
        bus_write(ADDR_CTRL, 16'h0001);
        wait_done();
    endtask

    // sample STATUS a chosen number of cycles after the start ack
    task automatic timing_probe(input int gap);
        logic [WORD_W-1:0] status;
        int start;
        int elapsed;
        bus_write(ADDR_CTRL, 16'h0001);
        start = ack_cycle;
        repeat (gap) @(posedge clk_i);
        bus_read(ADDR_STATUS, status);
        elapsed = ack_cycle - start;
        check_word($sformatf("status at +%0d", elapsed),
                   (elapsed >= KERNEL_N + 4) ? 16'h0002 : 16'h0001, status);
        wait_done();
    endtask

    initial begin
        logic [WORD_W-1:0] rd;
        int first_ack;
        int second_ack;
        int done_ack;
        void'($urandom(86605));
        clk_i    = 1'b0;
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (8) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);

        // reset state, unmapped and read-only addresses
        bus_read(ADDR_STATUS, rd);
        check_word("status", 16'h0000, rd);
        for (int n = 0; n < NUM_NODES; n++) begin
            bus_read(ADDR_RESULT + ADR_W'(n), rd);
            check_word($sformatf("result%0d", n), 16'h0000, rd);
        end
        bus_read(8'h30, rd);
        check_word("unmapped read", 16'h0000, rd);
        bus_write(ADDR_STATUS, 16'h0003);
        bus_write(ADDR_RESULT, 16'h1234);
        bus_read(ADDR_STATUS, rd);
        check_word("status", 16'h0000, rd);
        bus_read(ADDR_RESULT, rd);
        check_word("result0", 16'h0000, rd);

        fill_random(-20, 20);
        load_operands();
        run_batch();
        check_results();

        // nodes 2 and 3 end up below the bias
        bias_m = 16'sd5;
        for (int t = 0; t < KERNEL_N; t++) begin
            kernel_m[t]     = 16'sd3;
            windows_m[0][t] = 16'sd4;
            windows_m[1][t] = 16'sd1;
            windows_m[2][t] = -16'sd2;
            windows_m[3][t] = 16'sd0;
        end
        load_operands();
        run_batch();
        check_results();

        fill_random(200, 1200);
        load_operands();
        run_batch();
        for (int n = 0; n < NUM_NODES; n++) begin
            bus_read(ADDR_RESULT + ADR_W'(n), rd);
            check_word($sformatf("result%0d", n), 16'h7FFF, rd);
        end

        // a second start while busy must be dropped
        fill_random(-20, 20);
        load_operands();
        bus_write(ADDR_CTRL, 16'h0001);
        first_ack = ack_cycle;
        bus_read(ADDR_STATUS, rd);
        check_word("status while running", 16'h0001, rd);
        bus_write(ADDR_CTRL, 16'h0001);
        second_ack = ack_cycle;
        wait_done();
        done_ack = ack_cycle;
        if (done_ack - first_ack < KERNEL_N + 4 || done_ack >= second_ack + KERNEL_N + 4)
            abort_run("done came at the wrong time after a start written while busy");
        check_results();
        for (int n = 0; n < NUM_NODES; n++)
            for (int t = 0; t < KERNEL_N; t++)
                windows_m[n][t] = rand_word(-20, 20);
        load_operands();
        run_batch();
        check_results();

        // probes land on both sides of the done edge
        for (int gap = 4; gap < 10; gap++)
            timing_probe(gap);
        check_results();

        if (dut_i.chk_i.error_count == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("Checks failed");
            $fatal(1);
        end
    end

endmodule

// ==== project.f ====
common/conv_pkg.sv
src/conv_wb_regs.sv
conv_node/conv_node.sv
src/conv_window_loader.sv
src/conv_result_collector.sv
src/conv_layer_top.sv
tb/conv_layer_chk.sv
tb/conv_layer_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the conv layer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module conv_layer_tb \
    -o conv_layer_sim || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/conv_layer_sim 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -q "All checks passed" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
